// ==== design/spi_periph_pkg.sv ====
// spi peripheral controller definitions
package spi_periph_pkg;

  // frame layout, address in the high nibble, data in the low nibble
  localparam int frame_bits = 8;
  localparam int addr_bits  = 4;
  localparam int data_bits  = 4;

  // register map
  localparam int reg_led_addr   = 1;
  localparam int reg_sel_addr   = 2;
  localparam int reg_blink_addr = 3;

  // select codes for the chip select router
  localparam int sel_adc = 1;
  localparam int sel_dac = 2;

  // led and blink sizing
  localparam int num_leds         = 4;
  localparam int blink_base_shift = 2;
  localparam int blink_rate_bits  = 3;
  localparam int blink_cnt_bits   = num_leds + blink_base_shift + 7;

  // input synchronizer depth
  localparam int sync_stages = 2;

  // bit counter saturates one past a full frame
  localparam int bit_cnt_bits = $clog2(frame_bits + 2);

endpackage

// ==== design/spi_frame_rx.sv ====
// spi frame receiver
`timescale 1ns/10ps

module spi_frame_rx
  import spi_periph_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  sclk,
  input  logic                  cs_n,
  input  logic                  mosi,
  input  logic                  special,
  output logic [frame_bits-1:0] frame,
  output logic                  frame_valid,
  output logic                  cs_n_sync,
  output logic                  bus_idle
);

  // synchronizer chains, newest sample in bit 0
  logic [sync_stages-1:0] sclk_q;
  logic [sync_stages-1:0] cs_q;
  logic [sync_stages-1:0] mosi_q;
  logic [sync_stages-1:0] spec_q;

  logic sclk_sync;
  logic mosi_sync;
  logic special_sync;

  // previous synchronized values for edge detect
  logic sclk_d;
  logic cs_d;
  logic sclk_rise;
  logic cs_rise;

  logic [bit_cnt_bits-1:0] bit_cnt;
  logic                    special_seen;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sclk_q <= '0;
      // cs idles high
      cs_q   <= '1;
      mosi_q <= '0;
      spec_q <= '0;
    end
    else
    begin
      sclk_q <= {sclk_q[sync_stages-2:0], sclk};
      cs_q   <= {cs_q[sync_stages-2:0], cs_n};
      mosi_q <= {mosi_q[sync_stages-2:0], mosi};
      spec_q <= {spec_q[sync_stages-2:0], special};
    end
  end

  assign sclk_sync    = sclk_q[sync_stages-1];
  assign cs_n_sync    = cs_q[sync_stages-1];
  assign mosi_sync    = mosi_q[sync_stages-1];
  assign special_sync = spec_q[sync_stages-1];
  assign bus_idle     = cs_n_sync;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sclk_d <= 1'b0;
      cs_d   <= 1'b1;
    end
    else
    begin
      sclk_d <= sclk_sync;
      cs_d   <= cs_n_sync;
    end
  end

  assign sclk_rise = sclk_sync & ~sclk_d;
  // end of transfer
  assign cs_rise   = cs_n_sync & ~cs_d;

  // msb first shift, only while selected
  always_ff @(posedge clk)
  begin
    if (!cs_n_sync && sclk_rise)
      frame <= {frame[frame_bits-2:0], mosi_sync};
  end

  // count edges and track special over the transfer
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      bit_cnt      <= '0;
      special_seen <= 1'b0;
    end
    else if (cs_n_sync)
    begin
      // idle, ready for the next transfer
      bit_cnt      <= '0;
      special_seen <= 1'b0;
    end
    else
    begin
      // saturate one past frame_bits so 9+ edges stay invalid
      if (sclk_rise && bit_cnt != bit_cnt_bits'(frame_bits + 1))
        bit_cnt <= bit_cnt + 1'b1;
      if (special_sync)
        special_seen <= 1'b1;
    end
  end

  // old count and flag are still visible on the cs rising cycle
  always_ff @(posedge clk)
  begin
    if (rst)
      frame_valid <= 1'b0;
    else
      frame_valid <= cs_rise && (bit_cnt == bit_cnt_bits'(frame_bits))
                     && !special_seen && !special_sync;
  end

endmodule

// ==== design/reg_bank.sv ====
// register bank
`timescale 1ns/10ps

module reg_bank
  import spi_periph_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic [frame_bits-1:0]      frame,
  input  logic                       frame_valid,
  output logic [data_bits-1:0]       led_reg,
  output logic [addr_bits-1:0]       periph_sel,
  output logic                       blink_en,
  output logic [blink_rate_bits-1:0] blink_rate
);

  // frame fields
  logic [addr_bits-1:0] addr;
  logic [data_bits-1:0] data;

  // raw blink control nibble
  logic [data_bits-1:0] blink_reg;

  assign addr = frame[frame_bits-1 -: addr_bits];
  assign data = frame[data_bits-1:0];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      led_reg    <= '0;
      periph_sel <= '0;
      blink_reg  <= '0;
    end
    else if (frame_valid)
    begin
      case (addr)
        addr_bits'(reg_led_addr):
        begin
          led_reg <= data;
        end
        addr_bits'(reg_sel_addr):
        begin
          // data nibble is the select code
          periph_sel <= data;
        end
        addr_bits'(reg_blink_addr):
        begin
          blink_reg <= data;
        end
        default:
        begin
          // unmapped address, frame ignored
        end
      endcase
    end
  end

  // top bit enables, low bits give the rate
  assign blink_en   = blink_reg[data_bits-1];
  assign blink_rate = blink_reg[blink_rate_bits-1:0];

endmodule

// ==== design/cs_router.sv ====
// chip select router
`timescale 1ns/10ps

module cs_router
  import spi_periph_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cs_n,
  input  logic                 special,
  input  logic                 bus_idle,
  input  logic [addr_bits-1:0] periph_sel,
  output logic                 adc_cs_n,
  output logic                 dac_cs_n
);

  // target held for the current routed transfer
  logic [addr_bits-1:0] route;
  logic                 route_load;
  logic                 to_adc;
  logic                 to_dac;

  // frozen while a routed transfer is active
  assign route_load = bus_idle || !special;

  always_ff @(posedge clk)
  begin
    if (rst)
      route <= '0;
    else if (route_load)
      route <= periph_sel;
  end

  assign to_adc = special && (route == addr_bits'(sel_adc));
  assign to_dac = special && (route == addr_bits'(sel_dac));

  // raw pin passes straight through, no added latency
  always_comb
  begin
    adc_cs_n = 1'b1;
    dac_cs_n = 1'b1;
    if (to_adc)
      adc_cs_n = cs_n;
    else if (to_dac)
      dac_cs_n = cs_n;
    // unknown route keeps both deasserted
  end

endmodule

// ==== design/led_driver.sv ====
// led driver with gray code blink
`timescale 1ns/10ps

module led_driver
  import spi_periph_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic [data_bits-1:0]       led_reg,
  input  logic                       blink_en,
  input  logic [blink_rate_bits-1:0] blink_rate,
  output logic [num_leds-1:0]        led
);

  logic [blink_cnt_bits-1:0]  counter;
  logic [blink_rate_bits:0]   shift_amt;
  logic [blink_cnt_bits-1:0]  shifted;
  logic [num_leds-1:0]        bin;
  logic [num_leds-1:0]        gray;

  // free running
  always_ff @(posedge clk)
  begin
    if (rst)
      counter <= '0;
    else
      counter <= counter + 1'b1;
  end

  // base shift plus programmable rate
  assign shift_amt = {1'b0, blink_rate} + (blink_rate_bits + 1)'(blink_base_shift);
  assign shifted   = counter >> shift_amt;
  assign bin       = shifted[num_leds-1:0];

  // neighbours differ in one bit, wrap included
  assign gray = bin ^ (bin >> 1);

  always_ff @(posedge clk)
  begin
    if (rst)
      led <= '0;
    else if (blink_en)
      led <= gray;
    else
      led <= num_leds'(led_reg);
  end

endmodule

// ==== design/spi_periph_top.sv ====
// spi peripheral controller top
`timescale 1ns/10ps

module spi_periph_top
  import spi_periph_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                sclk,
  input  logic                cs_n,
  input  logic                mosi,
  input  logic                special,
  output logic                adc_cs_n,
  output logic                dac_cs_n,
  output logic [num_leds-1:0] led
);

  // receiver to register bank
  logic [frame_bits-1:0] frame;
  logic                  frame_valid;

  // receiver bus state
  logic bus_idle;

  // register outputs
  logic [data_bits-1:0]       led_reg;
  logic [addr_bits-1:0]       periph_sel;
  logic                       blink_en;
  logic [blink_rate_bits-1:0] blink_rate;

  spi_frame_rx rx_i (
    .clk         (clk),
    .rst         (rst),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .special     (special),
    .frame       (frame),
    .frame_valid (frame_valid),
    .cs_n_sync   (),
    .bus_idle    (bus_idle)
  );

  reg_bank regs_i (
    .clk         (clk),
    .rst         (rst),
    .frame       (frame),
    .frame_valid (frame_valid),
    .led_reg     (led_reg),
    .periph_sel  (periph_sel),
    .blink_en    (blink_en),
    .blink_rate  (blink_rate)
  );

  // raw pin cs_n for the routed path
  cs_router router_i (
    .clk        (clk),
    .rst        (rst),
    .cs_n       (cs_n),
    .special    (special),
    .bus_idle   (bus_idle),
    .periph_sel (periph_sel),
    .adc_cs_n   (adc_cs_n),
    .dac_cs_n   (dac_cs_n)
  );

  led_driver leds_i (
    .clk        (clk),
    .rst        (rst),
    .led_reg    (led_reg),
    .blink_en   (blink_en),
    .blink_rate (blink_rate),
    .led        (led)
  );

endmodule

// ==== sim/spi_periph_assert.sv ====
// chip select and reset assertions
`timescale 1ns/10ps

module spi_periph_assert
  import spi_periph_pkg::*;
(
  input logic                clk,
  input logic                rst,
  input logic                special,
  input logic                adc_cs_n,
  input logic                dac_cs_n,
  input logic [num_leds-1:0] led
);

  // running count of failed properties
  int fail_count = 0;

  // at most one peripheral selected
  cs_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(!adc_cs_n && !dac_cs_n))
    else
    begin
      fail_count++;
      $error("adc_cs_n and dac_cs_n both asserted");
    end

  // no routing unless special is high
  cs_idle: assert property (@(posedge clk) disable iff (rst)
    !special |-> (adc_cs_n && dac_cs_n))
    else
    begin
      fail_count++;
      $error("chip select asserted while special is low");
    end

  // leds cleared by reset
  led_reset: assert property (@(posedge clk)
    rst |=> (led == '0))
    else
    begin
      fail_count++;
      $error("led not zero after reset");
    end

endmodule

bind spi_periph_top spi_periph_assert assert_i (
  .clk      (clk),
  .rst      (rst),
  .special  (special),
  .adc_cs_n (adc_cs_n),
  .dac_cs_n (dac_cs_n),
  .led      (led)
);

// ==== sim/spi_periph_tb.sv ====
// spi peripheral controller testbench
`timescale 1ns/10ps

module spi_periph_tb
  import spi_periph_pkg::*;
();

  // sclk half period in clk cycles
  localparam int half_cycles   = 4;
  localparam int led_timeout   = 20;
  // cs_n rise to led, 2 sync + edge + valid + register
  localparam int write_latency = 5;
  localparam int blink_changes = 40;

  logic                clk;
  logic                rst;
  logic                sclk;
  logic                cs_n;
  logic                mosi;
  logic                special;
  logic                adc_cs_n;
  logic                dac_cs_n;
  logic [num_leds-1:0] led;

  // stimulus and expected values, one row per transfer
  string               row_name[$];
  logic                row_spec[$];
  int                  row_nbits[$];
  logic [15:0]         row_bits[$];
  logic [num_leds-1:0] row_led[$];
  logic                row_hold[$];
  int                  row_route[$];

  int seed;

  spi_periph_top dut_i (
    .clk      (clk),
    .rst      (rst),
    .sclk     (sclk),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .special  (special),
    .adc_cs_n (adc_cs_n),
    .dac_cs_n (dac_cs_n),
    .led      (led)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // lands 1 ns after the edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic print_error(input string line);
    $display("%s", line);
    $display("Testbench failed");
  endtask

  function automatic logic [15:0] frame_word(input logic [3:0] addr, input logic [3:0] data);
    return {8'h00, addr, data};
  endfunction

  task automatic add_row(input string name, input logic spec, input int nbits,
                         input logic [15:0] bits, input logic [num_leds-1:0] exp_led,
                         input logic hold, input int route);
    row_name.push_back(name);
    row_spec.push_back(spec);
    row_nbits.push_back(nbits);
    row_bits.push_back(bits);
    row_led.push_back(exp_led);
    row_hold.push_back(hold);
    row_route.push_back(route);
  endtask

  task automatic check_route(input string name, input int route);
    logic exp_adc;
    logic exp_dac;
    // only the matching target follows the pin
    exp_adc = !(special && !cs_n && route == sel_adc);
    exp_dac = !(special && !cs_n && route == sel_dac);
    assert (adc_cs_n === exp_adc && dac_cs_n === exp_dac)
    else
    begin
      print_error($sformatf("Error: %s expected adc/dac cs_n %b%b actual %b%b",
                            name, exp_adc, exp_dac, adc_cs_n, dac_cs_n));
      $fatal(1);
    end
  endtask

  // msb first, sampled on sclk rising edge
  task automatic spi_transfer(input string name, input logic spec, input int nbits,
                              input logic [15:0] bits, input int route);
    logic [15:0] shreg;
    shreg   = bits << (16 - nbits);
    special = spec;
    wait_cycles(half_cycles);
    check_route(name, route);
    cs_n = 1'b0;
    wait_cycles(half_cycles);
    check_route(name, route);
    repeat (nbits)
    begin
      mosi  = shreg[15];
      shreg = {shreg[14:0], 1'b0};
      wait_cycles(half_cycles);
      sclk = 1'b1;
      wait_cycles(half_cycles);
      check_route(name, route);
      sclk = 1'b0;
    end
    wait_cycles(half_cycles);
    cs_n = 1'b1;
    wait_cycles(half_cycles);
    check_route(name, route);
    // special held past the cs_n rise
    special = 1'b0;
    mosi    = 1'b0;
  endtask

  // routed access with no clocks, never a frame
  task automatic probe_route(input string name, input int route);
    special = 1'b1;
    wait_cycles(half_cycles);
    cs_n = 1'b0;
    wait_cycles(half_cycles);
    check_route(name, route);
    cs_n = 1'b1;
    wait_cycles(half_cycles);
    check_route(name, route);
    special = 1'b0;
    wait_cycles(half_cycles);
  endtask

  task automatic wait_led(input string name, input logic [num_leds-1:0] exp);
    int cnt;
    cnt = 0;
    while (led !== exp && cnt < led_timeout)
    begin
      wait_cycles(1);
      cnt++;
    end
    assert (led === exp)
    else
    begin
      print_error($sformatf("Error: %s expected led %h actual %h", name, exp, led));
      $fatal(1);
    end
  endtask

  // dropped frame, led must not move
  task automatic hold_led(input string name, input logic [num_leds-1:0] exp);
    int cnt;
    for (cnt = 0; cnt < led_timeout; cnt++)
    begin
      wait_cycles(1);
      assert (led === exp)
      else
      begin
        print_error($sformatf("Error: %s expected led %h actual %h", name, exp, led));
        $fatal(1);
      end
    end
  endtask

  task automatic wait_led_change(input int step, input logic [num_leds-1:0] prev);
    int cnt;
    cnt = 0;
    while (led === prev && cnt < led_timeout)
    begin
      wait_cycles(1);
      cnt++;
    end
    assert (led !== prev)
    else
    begin
      print_error($sformatf("Timeout: blink step %0d, led stayed at %h for %0d cycles",
                            step, prev, led_timeout));
      $fatal(1);
    end
  endtask

  initial
  begin : main
    int                  i;
    int                  step;
    logic [num_leds-1:0] nib;
    logic [num_leds-1:0] last;
    logic [num_leds-1:0] prev;

    rst     = 1'b1;
    sclk    = 1'b0;
    cs_n    = 1'b1;
    mosi    = 1'b0;
    special = 1'b0;
    seed    = 32'h4da7_f0bf;

    // led writes with random data
    last = '0;
    for (i = 0; i < 6; i++)
    begin
      nib = num_leds'($random(seed));
      // every write has to move the led
      if (nib == last)
        nib = ~nib;
      add_row($sformatf("led_write_%0d", i), 1'b0, frame_bits,
              frame_word(4'(reg_led_addr), nib), nib, 1'b0, 0);
      last = nib;
    end
    // bad frames, led stays put
    // 9 bit row leaves a zero lsb, so a taken 7 bit frame decodes as the led address
    add_row("drop_9_bits", 1'b0, 9, frame_word(4'(reg_led_addr), ~last & 4'he),
            last, 1'b1, 0);
    add_row("drop_7_bits", 1'b0, 7, frame_word(4'(reg_led_addr), ~last), last, 1'b1, 0);
    add_row("drop_special", 1'b1, frame_bits, frame_word(4'(reg_led_addr), ~last),
            last, 1'b1, 0);
    add_row("drop_addr_0", 1'b0, frame_bits, frame_word(4'h0, ~last), last, 1'b1, 0);
    add_row("drop_addr_7", 1'b0, frame_bits, frame_word(4'h7, ~last), last, 1'b1, 0);
    // routing, frozen row tries to retarget during an adc transfer
    add_row("route_adc", 1'b0, frame_bits, frame_word(4'(reg_sel_addr), 4'(sel_adc)),
            last, 1'b1, sel_adc);
    add_row("route_frozen", 1'b1, frame_bits, frame_word(4'(reg_sel_addr), 4'(sel_dac)),
            last, 1'b1, sel_adc);
    add_row("route_dac", 1'b0, frame_bits, frame_word(4'(reg_sel_addr), 4'(sel_dac)),
            last, 1'b1, sel_dac);
    add_row("route_unknown", 1'b0, frame_bits, frame_word(4'(reg_sel_addr), 4'h5),
            last, 1'b1, 5);

    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    wait_cycles(1);
    assert (led === '0 && adc_cs_n === 1'b1 && dac_cs_n === 1'b1)
    else
    begin
      print_error($sformatf("Error: reset expected led 0 cs_n 11 actual led %h cs_n %b%b",
                            led, adc_cs_n, dac_cs_n));
      $fatal(1);
    end

    for (i = 0; i < row_name.size(); i++)
    begin
      spi_transfer(row_name[i], row_spec[i], row_nbits[i], row_bits[i], row_route[i]);
      if (row_hold[i])
        hold_led(row_name[i], row_led[i]);
      else
        wait_led(row_name[i], row_led[i]);
      probe_route(row_name[i], row_route[i]);
    end

    // blink on at rate 0, each step one bit
    spi_transfer("blink_on", 1'b0, frame_bits, frame_word(4'(reg_blink_addr), 4'b1000), 0);
    wait_cycles(write_latency);
    prev = led;
    for (step = 0; step < blink_changes; step++)
    begin
      wait_led_change(step, prev);
      assert ($countones(led ^ prev) == 1)
      else
      begin
        print_error($sformatf("Error: blink_step_%0d expected 1 changed bit actual %0d",
                              step, $countones(led ^ prev)));
        $fatal(1);
      end
      prev = led;
    end

    // blink off brings back the led register and keeps it
    spi_transfer("blink_off", 1'b0, frame_bits, frame_word(4'(reg_blink_addr), 4'h0), 0);
    wait_led("blink_off", last);
    hold_led("blink_off", last);

    // bound checker failures end the run too
    if (dut_i.assert_i.fail_count == 0)
    begin
      $display("Testbench passed");
      $finish;
    end
    else
    begin
      print_error($sformatf("Concurrent assertions failed %0d times",
                            dut_i.assert_i.fail_count));
      $fatal(1);
    end
  end

endmodule

// ==== vlog.f ====
design/spi_periph_pkg.sv
design/spi_frame_rx.sv
design/reg_bank.sv
design/cs_router.sv
design/led_driver.sv
design/spi_periph_top.sv
sim/spi_periph_assert.sv
sim/spi_periph_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = spi_periph_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Testbench failed
PASS_MSG  = Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended early, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
